// ==== include/z80_io_cfg.svh ====
`ifndef Z80_IO_CFG_SVH
`define Z80_IO_CFG_SVH

// I/O port map
`define Z80_PORT_ESPCTRL  8'hF4     // ESP control / status
`define Z80_PORT_ESPDATA  8'hF5     // ESP transmit / receive data
`define Z80_PORT_CASSETTE 8'hFC
`define Z80_PORT_CPM      8'hFD     // CP/M remap, write only
`define Z80_PORT_PRINTER  8'hFE
`define Z80_PORT_SCRAMBLE 8'hFF     // Write only

// Memory window of the system RAM, A[15:11]
`define Z80_RAM_REGION 5'b00111     // $3800-$3FFF

// ESP serial port
`define ESP_BIT_CYCLES 8            // sysclk cycles per bit
`define ESP_BREAK_BITS 12           // Bit times of a sent break

`endif

// ==== source/z80_io_pkg.sv ====
package z80_io_pkg;

    // Memory request view, A[15:11] picks a 2 KB region
    typedef struct packed {
        logic [4:0]  region;
        logic [10:0] offset;
    } mem_view_t;

    // I/O request view, only the low byte is the port
    typedef struct packed {
        logic [7:0] high;
        logic [7:0] port;
    } io_view_t;

    // One address word, read through whichever view the request calls for
    typedef union packed {
        mem_view_t mem;
        io_view_t  io;
    } bus_addr_t;

    // Read word of the ESP control/status port
    typedef struct packed {
        logic [2:0] zero;
        logic       overflow;       // Sticky
        logic       framing;        // Sticky
        logic       brk;            // Sticky
        logic       tx_busy;
        logic       rx_not_empty;
    } esp_status_t;

endpackage

// ==== source/bus_access_if.sv ====
`timescale 1ns/1ps

// One decoded CPU access, front end to the processing blocks
interface bus_access_if;

    z80_io_pkg::bus_addr_t addr;
    logic [7:0]            wrdata;
    logic                  wr_stb;      // One cycle per write cycle
    logic                  rd_stb;      // One cycle per read cycle
    logic                  sel_ram;
    logic                  sel_port;    // I/O request on one of our ports

    modport front (
        output addr,
        output wrdata,
        output wr_stb,
        output rd_stb,
        output sel_ram,
        output sel_port
    );

    modport proc (
        input addr,
        input wrdata,
        input wr_stb,
        input rd_stb,
        input sel_ram,
        input sel_port
    );

endinterface

// ==== source/bus_front.sv ====
`timescale 1ns/1ps
`include "z80_io_cfg.svh"

module bus_front (
    input  logic        sysclk,
    input  logic        reset,
    input  logic [15:0] bus_a,
    input  logic [7:0]  bus_d_in,
    input  logic        bus_rd_n,
    input  logic        bus_wr_n,
    input  logic        bus_mreq_n,
    input  logic        bus_iorq_n,
    output logic [7:0]  bus_d_out,
    output logic        bus_d_oe,
    bus_access_if.front acc,
    input  logic [7:0]  ram_rddata,
    input  logic [7:0]  port_rddata
);

    logic [2:0]            wr_n_r;
    logic [2:0]            rd_n_r;
    logic [7:0]            wrdata_r;
    z80_io_pkg::bus_addr_t addr;
    logic                  sel_ram;
    logic                  sel_port;

    ////////////////////////////////////////////////////////////////////
    // Strobe synchronizers
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            wr_n_r <= 3'b111;           // Bus idle
            rd_n_r <= 3'b111;
        end else begin
            wr_n_r <= {wr_n_r[1:0], bus_wr_n};
            rd_n_r <= {rd_n_r[1:0], bus_rd_n};
        end
    end

    // Falling edge seen in the last two stages
    assign acc.wr_stb = wr_n_r[2] & ~wr_n_r[1];
    assign acc.rd_stb = rd_n_r[2] & ~rd_n_r[1];

    // Data is stable long before the strobe pulse
    always_ff @(posedge sysclk) begin
        if (!bus_wr_n)
            wrdata_r <= bus_d_in;
    end

    assign acc.wrdata = wrdata_r;

    ////////////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////////////
    assign addr     = bus_a;
    assign sel_ram  = !bus_mreq_n && addr.mem.region == `Z80_RAM_REGION;
    assign sel_port = !bus_iorq_n && (addr.io.port inside {
                          `Z80_PORT_ESPCTRL, `Z80_PORT_ESPDATA,
                          `Z80_PORT_CASSETTE, `Z80_PORT_CPM,
                          `Z80_PORT_PRINTER, `Z80_PORT_SCRAMBLE});

    assign acc.addr     = addr;
    assign acc.sel_ram  = sel_ram;
    assign acc.sel_port = sel_port;

    // Read data back to the CPU
    always_comb begin
        if (sel_ram)
            bus_d_out = ram_rddata;     // Registered, settles after one cycle
        else if (sel_port)
            bus_d_out = port_rddata;
        else
            bus_d_out = 8'h00;
    end

    // Only drive the bus for our own selects
    assign bus_d_oe = !bus_rd_n && (sel_ram || sel_port);

endmodule

// ==== source/io_regs.sv ====
`timescale 1ns/1ps
`include "z80_io_cfg.svh"

module io_regs (
    input  logic       sysclk,
    input  logic       reset,
    bus_access_if.proc acc,
    output logic [7:0] port_rddata,
    input  logic       cassette_in,
    input  logic       printer_in,
    output logic       cassette_out,
    output logic       printer_out,
    output logic       cpm_remap,
    output logic [7:0] scramble_value,
    output logic [7:0] tx_data,
    output logic       tx_valid,
    output logic       tx_break,
    input  logic       tx_busy,
    input  logic [7:0] rx_data,
    input  logic       rx_not_empty,
    output logic       rx_read,
    input  logic       rx_overflow,
    input  logic       rx_framing,
    input  logic       rx_break
);

    logic [7:0]              port;
    logic                    wr_hit;
    logic                    wr_ctrl;
    logic [2:0]              flags;     // Overflow, framing, break
    logic [2:0]              clr_mask;
    z80_io_pkg::esp_status_t status;

    assign port    = acc.addr.io.port;
    assign wr_hit  = acc.wr_stb && acc.sel_port;
    assign wr_ctrl = wr_hit && port == `Z80_PORT_ESPCTRL;

    // UART requests straight off the access strobes
    assign tx_data  = acc.wrdata;
    assign tx_valid = wr_hit && port == `Z80_PORT_ESPDATA;
    assign tx_break = wr_ctrl && acc.wrdata[7];
    assign rx_read  = acc.rd_stb && acc.sel_port && port == `Z80_PORT_ESPDATA;

    // Latch ports
    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            cassette_out   <= 1'b0;
            cpm_remap      <= 1'b0;
            printer_out    <= 1'b0;
            scramble_value <= 8'h00;
        end else if (wr_hit) begin
            if (port == `Z80_PORT_CASSETTE) cassette_out   <= acc.wrdata[0];
            if (port == `Z80_PORT_CPM)      cpm_remap      <= acc.wrdata[0];
            if (port == `Z80_PORT_PRINTER)  printer_out    <= acc.wrdata[0];
            if (port == `Z80_PORT_SCRAMBLE) scramble_value <= acc.wrdata;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Sticky ESP error flags
    ////////////////////////////////////////////////////////////////////
    assign clr_mask = wr_ctrl ? acc.wrdata[4:2] : 3'b000;

    always_ff @(posedge sysclk or posedge reset) begin
        if (reset)
            flags <= 3'b000;
        else    // A new event beats a clear in the same cycle
            flags <= (flags & ~clr_mask) | {rx_overflow, rx_framing, rx_break};
    end

    always_comb begin
        status              = '0;
        status.overflow     = flags[2];
        status.framing      = flags[1];
        status.brk          = flags[0];
        status.tx_busy      = tx_busy;
        status.rx_not_empty = rx_not_empty;
    end

    // Port read word, write-only ports read as zero
    always_comb begin
        case (port)
            `Z80_PORT_ESPCTRL:  port_rddata = status;
            `Z80_PORT_ESPDATA:  port_rddata = rx_data;
            `Z80_PORT_CASSETTE: port_rddata = {7'b0, cassette_in};
            `Z80_PORT_PRINTER:  port_rddata = {7'b0, printer_in};
            default:            port_rddata = 8'h00;
        endcase
    end

endmodule

// ==== source/sys_ram.sv ====
`timescale 1ns/1ps

module sys_ram (
    input  logic       sysclk,
    bus_access_if.proc acc,
    output logic [7:0] rddata
);

    logic [7:0] mem [2048];

    // Write on the strobe, read every cycle from the current offset
    always_ff @(posedge sysclk) begin
        if (acc.sel_ram && acc.wr_stb)
            mem[acc.addr.mem.offset] <= acc.wrdata;
        rddata <= mem[acc.addr.mem.offset];
    end

endmodule

// ==== source/esp_uart.sv ====
`timescale 1ns/1ps
`include "z80_io_cfg.svh"

module esp_uart (
    input  logic       sysclk,
    input  logic       reset,
    input  logic [7:0] tx_data,
    input  logic       tx_valid,
    input  logic       tx_break,
    output logic       tx_busy,
    output logic [7:0] rx_data,
    output logic       rx_not_empty,
    input  logic       rx_read,
    output logic       rx_overflow,
    output logic       rx_framing,
    output logic       rx_break,
    input  logic       esp_rx,
    input  logic       esp_cts,
    output logic       esp_tx,
    output logic       esp_rts
);

    localparam int cnt_max = (`ESP_BREAK_BITS > 10) ? `ESP_BREAK_BITS : 10;
    localparam int div_w   = $clog2(`ESP_BIT_CYCLES + 1);
    localparam int bit_w   = $clog2(cnt_max + 1);
    localparam logic [div_w-1:0] div_last = div_w'(`ESP_BIT_CYCLES - 1);
    localparam logic [div_w-1:0] div_half = div_w'((`ESP_BIT_CYCLES - 1) / 2);

    logic [1:0]       cts_sync;
    logic             tx_pending;       // Loaded, waiting for CTS
    logic             tx_active;
    logic             brk_active;
    logic             tx_line;
    logic             tx_engaged;
    logic             tx_accept;
    logic             tx_go;
    logic             brk_go;
    logic             tx_tick;
    logic [7:0]       tx_hold;
    logic [8:0]       tx_frame;         // Remaining data bits and stop bit
    logic [div_w-1:0] tx_div;
    logic [bit_w-1:0] tx_bits;

    logic [2:0]       rx_sync;
    logic             rx_s;
    logic             rx_active;
    logic             rx_sample;
    logic             rx_stop;
    logic             rx_good;
    logic             rx_store;
    logic             rx_full;
    logic [div_w-1:0] rx_div;
    logic [bit_w-1:0] rx_bits;
    logic [7:0]       rx_shift;
    logic [7:0]       rx_buf;

    ////////////////////////////////////////////////////////////////////
    // Transmitter
    ////////////////////////////////////////////////////////////////////
    assign tx_engaged = tx_pending | tx_active | brk_active;
    assign tx_busy    = tx_engaged | tx_valid;
    assign tx_accept  = tx_valid & ~tx_engaged;         // Otherwise dropped
    assign tx_go      = (tx_accept | tx_pending) & ~cts_sync[1];
    assign brk_go     = tx_break & ~tx_engaged;
    assign tx_tick    = tx_div == div_last;
    assign esp_tx     = tx_line;

    always_ff @(posedge sysclk) begin
        if (tx_accept)
            tx_hold <= tx_data;
        if (tx_go)
            tx_frame <= {1'b1, tx_accept ? tx_data : tx_hold};
        else if (tx_active && tx_tick)
            tx_frame <= {1'b1, tx_frame[8:1]};
    end

    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            cts_sync   <= 2'b11;
            tx_pending <= 1'b0;
            tx_active  <= 1'b0;
            brk_active <= 1'b0;
            tx_line    <= 1'b1;             // Idle high
            tx_div     <= '0;
            tx_bits    <= '0;
        end else begin
            cts_sync <= {cts_sync[0], esp_cts};
            tx_div   <= tx_tick ? '0 : tx_div + 1'b1;
            if (tx_go) begin
                tx_pending <= 1'b0;
                tx_active  <= 1'b1;
                tx_line    <= 1'b0;         // Start bit
                tx_div     <= '0;
                tx_bits    <= '0;
            end else if (tx_accept) begin
                tx_pending <= 1'b1;
            end else if (brk_go) begin
                brk_active <= 1'b1;
                tx_line    <= 1'b0;
                tx_div     <= '0;
                tx_bits    <= '0;
            end else if (tx_tick && tx_active) begin
                if (tx_bits == bit_w'(9)) begin
                    tx_active <= 1'b0;      // Stop bit done, line stays high
                end else begin
                    tx_line <= tx_frame[0];
                    tx_bits <= tx_bits + 1'b1;
                end
            end else if (tx_tick && brk_active) begin
                if (tx_bits == bit_w'(`ESP_BREAK_BITS - 1)) begin
                    brk_active <= 1'b0;
                    tx_line    <= 1'b1;
                end else begin
                    tx_bits <= tx_bits + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Receiver
    ////////////////////////////////////////////////////////////////////
    assign rx_s      = rx_sync[1];
    assign rx_sample = rx_active && rx_div == '0;       // Mid-cell
    assign rx_stop   = rx_sample && rx_bits == bit_w'(9);
    assign rx_good   = rx_stop && rx_s;
    assign rx_store  = rx_good && !(rx_full && !rx_read);

    assign rx_data      = rx_buf;
    assign rx_not_empty = rx_full;
    assign esp_rts      = rx_full;                       // Hold off the sender

    always_ff @(posedge sysclk) begin
        if (rx_sample && rx_bits != '0 && !rx_stop)
            rx_shift <= {rx_s, rx_shift[7:1]};          // LSB first
        if (rx_store)
            rx_buf <= rx_shift;
    end

    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            rx_sync     <= 3'b111;
            rx_active   <= 1'b0;
            rx_div      <= '0;
            rx_bits     <= '0;
            rx_full     <= 1'b0;
            rx_overflow <= 1'b0;
            rx_framing  <= 1'b0;
            rx_break    <= 1'b0;
        end else begin
            rx_sync     <= {rx_sync[1:0], esp_rx};
            rx_overflow <= rx_good && !rx_store;         // Old byte is kept
            rx_framing  <= rx_stop && !rx_s && rx_shift != 8'h00;
            rx_break    <= rx_stop && !rx_s && rx_shift == 8'h00;

            if (rx_store)
                rx_full <= 1'b1;
            else if (rx_read)
                rx_full <= 1'b0;

            if (!rx_active) begin
                // Falling edge only, so a held break cannot restart a frame
                if (rx_sync[2] && !rx_s) begin
                    rx_active <= 1'b1;
                    rx_div    <= div_half;
                    rx_bits   <= '0;
                end
            end else if (rx_div != '0) begin
                rx_div <= rx_div - 1'b1;
            end else begin
                rx_div  <= div_last;
                rx_bits <= rx_bits + 1'b1;
                if ((rx_bits == '0 && rx_s) || rx_stop)
                    rx_active <= 1'b0;      // Glitch or end of frame
            end
        end
    end

endmodule

// ==== source/z80_io_top.sv ====
`timescale 1ns/1ps

module z80_io_top (
    input  logic        sysclk,
    input  logic        reset,
    input  logic [15:0] bus_a,
    input  logic [7:0]  bus_d_in,
    input  logic        bus_rd_n,
    input  logic        bus_wr_n,
    input  logic        bus_mreq_n,
    input  logic        bus_iorq_n,
    output logic [7:0]  bus_d_out,
    output logic        bus_d_oe,
    input  logic        cassette_in,
    input  logic        printer_in,
    output logic        cassette_out,
    output logic        printer_out,
    output logic        cpm_remap,
    output logic [7:0]  scramble_value,
    input  logic        esp_rx,
    input  logic        esp_cts,
    output logic        esp_tx,
    output logic        esp_rts
);

    logic [7:0] ram_rddata;
    logic [7:0] port_rddata;

    // Register block to UART
    logic [7:0] tx_data;
    logic       tx_valid;
    logic       tx_break;
    logic       tx_busy;
    logic [7:0] rx_data;
    logic       rx_not_empty;
    logic       rx_read;
    logic       rx_overflow;
    logic       rx_framing;
    logic       rx_break;

    bus_access_if acc ();

    //////////////////////////////////////////////////////////////////////
    // Blocks, ports matched by name
    //////////////////////////////////////////////////////////////////////
    bus_front bus_front_i (.acc(acc.front), .*);

    io_regs io_regs_i (.acc(acc.proc), .*);

    sys_ram sys_ram_i (
        .sysclk(sysclk),
        .acc(acc.proc),
        .rddata(ram_rddata)
    );

    esp_uart esp_uart_i (.*);

endmodule

// ==== tests/z80_io_properties.sv ====
`timescale 1ns/1ps

module z80_io_properties (
    input logic sysclk,
    input logic reset,
    input logic bus_d_oe,
    input logic bus_rd_n,
    input logic bus_wr_n,
    input logic wr_stb,
    input logic rd_stb,
    input logic tx_busy,
    input logic brk_active,
    input logic esp_tx,
    input logic rx_read,
    input logic esp_rts
);

    int fail_count = 0;     // Failed assertions so far

    // Read strobe lands while the data bus is still driven
    oe_in_read: assert property (@(posedge sysclk) disable iff (reset)
        $rose(bus_d_oe) |-> ##2 (rd_stb && bus_d_oe && !bus_rd_n))
        else begin
            $error("read strobe missing inside a driven read cycle");
            fail_count++;
        end

    // Third edge after the first low sample and one cycle wide
    wr_pulse: assert property (@(posedge sysclk) disable iff (reset)
        $fell(bus_wr_n) |-> ##2 wr_stb ##1 !wr_stb)
        else begin
            $error("write strobe late, missing or wider than one cycle");
            fail_count++;
        end

    // Idle serial line is a mark
    tx_idle: assert property (@(posedge sysclk) disable iff (reset)
        (!tx_busy && !brk_active) |-> esp_tx)
        else begin
            $error("esp_tx low while the transmitter is idle");
            fail_count++;
        end

    // Full buffer keeps RTS up until the CPU reads it
    rts_full: assert property (@(posedge sysclk) disable iff (reset)
        (esp_rts && !rx_read) |=> esp_rts)
        else begin
            $error("esp_rts dropped without a receive buffer read");
            fail_count++;
        end

endmodule

bind z80_io_top z80_io_properties props_i (
    .sysclk(sysclk),
    .reset(reset),
    .bus_d_oe(bus_d_oe),
    .bus_rd_n(bus_rd_n),
    .bus_wr_n(bus_wr_n),
    .wr_stb(acc.wr_stb),
    .rd_stb(acc.rd_stb),
    .tx_busy(tx_busy),
    .brk_active(esp_uart_i.brk_active),
    .esp_tx(esp_tx),
    .rx_read(rx_read),
    .esp_rts(esp_rts)
);

// ==== tests/z80_io_tb.sv ====
`timescale 1ns/1ps
`include "z80_io_cfg.svh"

module z80_io_tb;

    localparam logic [15:0] ctrl_port = {8'h00, `Z80_PORT_ESPCTRL};
    localparam logic [15:0] data_port = {8'h00, `Z80_PORT_ESPDATA};

    logic        sysclk;
    logic        reset;
    logic [15:0] bus_a;
    logic [7:0]  bus_d_in;
    logic        bus_rd_n;
    logic        bus_wr_n;
    logic        bus_mreq_n;
    logic        bus_iorq_n;
    logic [7:0]  bus_d_out;
    logic        bus_d_oe;
    logic        cassette_in;
    logic        printer_in;
    logic        cassette_out;
    logic        printer_out;
    logic        cpm_remap;
    logic [7:0]  scramble_value;
    logic        esp_cts;
    logic        esp_rts;
    wire         esp_line;          // esp_tx looped back into esp_rx

    int          errors;
    int          timeouts;
    logic [31:0] lfsr;
    logic [7:0]  rd_data;
    logic        rd_oe;
    logic [7:0]  exp_mem [2048];    // RAM model
    logic [10:0] offs [12];

    z80_io_top dut_i (.esp_rx(esp_line), .esp_tx(esp_line), .*);

    initial begin
        sysclk = 1'b0;
        forever #4 sysclk = ~sysclk;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////
    // Galois LFSR stepped once per bit taken
    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
            v = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [7:0] status_word(input logic ovf, input logic frm,
                                               input logic brk, input logic busy,
                                               input logic rxne);
        z80_io_pkg::esp_status_t s;
        s = '0;
        s.overflow     = ovf;
        s.framing      = frm;
        s.brk          = brk;
        s.tx_busy      = busy;
        s.rx_not_empty = rxne;
        return s;
    endfunction

    task automatic expect_value(input string name, input logic [7:0] got,
                                input logic [7:0] exp);
        assert (got === exp)
            else begin
                $display("error: %s got %h expected %h", name, got, exp);
                errors++;
            end
    endtask

    task automatic bus_write(input logic io, input logic [15:0] a, input logic [7:0] d);
        @(negedge sysclk);
        bus_a      = a;
        bus_d_in   = d;
        bus_mreq_n = io;
        bus_iorq_n = !io;
        bus_wr_n   = 1'b0;
        repeat (6) @(negedge sysclk);
        bus_wr_n   = 1'b1;
        bus_mreq_n = 1'b1;
        bus_iorq_n = 1'b1;
        @(negedge sysclk);
    endtask

    task automatic bus_read(input logic io, input logic [15:0] a);
        @(negedge sysclk);
        bus_a      = a;
        bus_mreq_n = io;
        bus_iorq_n = !io;
        bus_rd_n   = 1'b0;
        repeat (5) @(negedge sysclk);
        rd_data    = bus_d_out;     // Last cycle of the read
        rd_oe      = bus_d_oe;
        @(negedge sysclk);
        bus_rd_n   = 1'b1;
        bus_mreq_n = 1'b1;
        bus_iorq_n = 1'b1;
        @(negedge sysclk);
    endtask

    // Poll the ESP status port
    task automatic wait_status(input logic [7:0] mask, input logic [7:0] value);
        int tries;
        tries = 0;
        do begin
            bus_read(1'b1, ctrl_port);
            tries++;
        end while ((rd_data & mask) != value && tries < 60);
        if ((rd_data & mask) != value) begin
            $display("timeout waiting for ESP status %h under mask %h", value, mask);
            timeouts++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////
    initial begin
        errors      = 0;
        timeouts    = 0;
        lfsr        = 32'd88814;
        reset       = 1'b1;
        bus_a       = '0;
        bus_d_in    = '0;
        bus_rd_n    = 1'b1;
        bus_wr_n    = 1'b1;
        bus_mreq_n  = 1'b1;
        bus_iorq_n  = 1'b1;
        cassette_in = 1'b0;
        printer_in  = 1'b0;
        esp_cts     = 1'b0;
        repeat (3) @(posedge sysclk);
        @(negedge sysclk);
        reset = 1'b0;

        // RAM window at $3800
        for (int i = 0; i < 12; i++) begin
            offs[i] = 11'(take_bits(11));
            exp_mem[offs[i]] = 8'(take_bits(8));
            bus_write(1'b0, {`Z80_RAM_REGION, offs[i]}, exp_mem[offs[i]]);
        end
        for (int i = 0; i < 12; i++) begin
            bus_read(1'b0, {`Z80_RAM_REGION, offs[i]});
            expect_value("bus_d_out", rd_data, exp_mem[offs[i]]);
            expect_value("bus_d_oe", {7'b0, rd_oe}, 8'h01);
        end
        bus_read(1'b1, 16'h0010);       // Not one of our ports
        expect_value("bus_d_oe", {7'b0, rd_oe}, 8'h00);

        // Latch ports and scramble register
        cassette_in = 1'b1;
        bus_write(1'b1, {8'h00, `Z80_PORT_CASSETTE}, 8'h01);
        bus_write(1'b1, {8'h00, `Z80_PORT_PRINTER}, 8'hFF);
        bus_write(1'b1, {8'h00, `Z80_PORT_CPM}, 8'h01);
        bus_write(1'b1, {8'h00, `Z80_PORT_SCRAMBLE}, 8'hC3);
        bus_write(1'b1, {8'h00, `Z80_PORT_CASSETTE}, 8'hFE);
        expect_value("cassette_out", {7'b0, cassette_out}, 8'h00);
        expect_value("printer_out", {7'b0, printer_out}, 8'h01);
        expect_value("cpm_remap", {7'b0, cpm_remap}, 8'h01);
        expect_value("scramble_value", scramble_value, 8'hC3);
        bus_read(1'b1, {8'h00, `Z80_PORT_CASSETTE});
        expect_value("bus_d_out", rd_data, 8'h01);
        cassette_in = 1'b0;
        printer_in  = 1'b1;
        bus_read(1'b1, {8'h00, `Z80_PORT_PRINTER});
        expect_value("bus_d_out", rd_data, 8'h01);

        // Serial loopback of one byte
        bus_write(1'b1, data_port, 8'h5A);
        wait_status(8'h01, 8'h01);
        expect_value("esp_rts", {7'b0, esp_rts}, 8'h01);
        bus_read(1'b1, data_port);
        expect_value("bus_d_out", rd_data, 8'h5A);
        bus_read(1'b1, ctrl_port);
        expect_value("esp status", rd_data, status_word(0, 0, 0, 0, 0));
        expect_value("esp_rts", {7'b0, esp_rts}, 8'h00);

        // Second byte into a full buffer
        bus_write(1'b1, data_port, 8'h11);
        wait_status(8'h02, 8'h00);
        bus_write(1'b1, data_port, 8'h22);
        wait_status(8'h02, 8'h00);
        bus_read(1'b1, ctrl_port);
        expect_value("esp status", rd_data, status_word(1, 0, 0, 0, 1));
        bus_read(1'b1, data_port);
        expect_value("bus_d_out", rd_data, 8'h11);
        bus_write(1'b1, ctrl_port, 8'h10);
        bus_read(1'b1, ctrl_port);
        expect_value("esp status", rd_data, status_word(0, 0, 0, 0, 0));

        // Break is flagged but not stored
        bus_write(1'b1, ctrl_port, 8'h80);
        wait_status(8'h02, 8'h00);
        bus_read(1'b1, ctrl_port);
        expect_value("esp status", rd_data, status_word(0, 0, 1, 0, 0));
        bus_write(1'b1, ctrl_port, 8'h04);

        // Transmit held off by CTS
        esp_cts = 1'b1;
        bus_write(1'b1, data_port, 8'h3C);
        repeat (3 * `ESP_BIT_CYCLES) begin
            @(negedge sysclk);
            expect_value("esp_tx", {7'b0, esp_line}, 8'h01);
        end
        bus_read(1'b1, ctrl_port);
        expect_value("esp status", rd_data, status_word(0, 0, 0, 1, 0));
        esp_cts = 1'b0;
        wait_status(8'h01, 8'h01);
        bus_read(1'b1, data_port);
        expect_value("bus_d_out", rd_data, 8'h3C);

        $display("value errors: %0d, timeouts: %0d, assertion failures: %0d",
                 errors, timeouts, dut_i.props_i.fail_count);
        if (errors == 0 && timeouts == 0 && dut_i.props_i.fail_count == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+include
source/z80_io_pkg.sv
source/bus_access_if.sv
source/bus_front.sv
source/io_regs.sv
source/sys_ram.sv
source/esp_uart.sv
source/z80_io_top.sv
tests/z80_io_properties.sv
tests/z80_io_tb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f filelist.f --top-module z80_io_tb

sim:
	verilator --binary --timing --assert -f filelist.f --top-module z80_io_tb -Mdir obj_dir
	./obj_dir/Vz80_io_tb +verilator+error+limit+100 | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
